//--- verilog/predictor_config.svh
`ifndef PREDICTOR_CONFIG_SVH
`define PREDICTOR_CONFIG_SVH

////////////////////////////////////////
// address split
////////////////////////////////////////
`define PRED_ADDR_WIDTH 32              // processor address width
`define PRED_INDEX_BITS 5               // 32 sets indexed by pc[7:3]
`define PRED_TAG_BITS   24              // pc[31:8] above the index

// upper kind bit set means an unconditional transfer
`define PRED_KIND_NONE  2'b00           // not a branch
`define PRED_KIND_COND  2'b01           // conditional branch

// fresh counters for history 11,10,01,00
`define PRED_CTR_BACK   8'b10_10_10_01  // backward branch leans taken
`define PRED_CTR_FWD    8'b10_01_01_01  // forward branch leans not taken

`endif

//--- verilog/predictorPkg.sv
`default_nettype none

`include "predictor_config.svh"

package predictorPkg;

    ////////////////////////////////////////
    // address related vectors
    ////////////////////////////////////////
    typedef logic [`PRED_ADDR_WIDTH-1:0] addrT;     // full instruction address
    typedef logic [`PRED_INDEX_BITS-1:0] indexT;    // set index
    typedef logic [`PRED_TAG_BITS-1:0]   tagT;      // stored tag
    typedef logic [`PRED_ADDR_WIDTH-3:0] targetT;   // target word address, pc[31:2]

    ////////////////////////////////////////
    // branch information
    ////////////////////////////////////////
    typedef logic [1:0] kindT;                      // instruction kind code
    typedef logic [1:0] counterT;                   // saturating counter, msb = taken

    // history entry, high to low:
    //   [9]   older outcome
    //   [8]   newer outcome
    //   [7:6] counter for history 11
    //   [5:4] counter for history 10
    //   [3:2] counter for history 01
    //   [1:0] counter for history 00
    typedef logic [9:0] historyT;

endpackage

`default_nettype wire

//--- verilog/historyNext.sv
`timescale 1ns/100ps
`default_nettype none

`include "predictor_config.svh"

module historyNext (
    input  wire                      fresh,     // build a new entry on install
    input  wire predictorPkg::kindT  kind,      // install kind
    input  wire                      backward,  // target below the instruction
    input  wire                      taken,     // outcome, install or resolve
    input  wire predictorPkg::historyT old,     // current entry for training
    output predictorPkg::historyT    next       // entry to write back
);
    import predictorPkg::*;

    historyT    freshHist;          // install result
    historyT    trainHist;          // resolve result
    logic [1:0] sel;                // outcome bits of the old entry
    counterT    cur;                // counter picked by sel
    counterT    bumped;             // counter after one step

    ////////////////////////////////////////
    // install rule
    ////////////////////////////////////////
    always_comb begin
        case (kind)
            `PRED_KIND_COND: begin
                freshHist = {backward, taken,
                             backward ? `PRED_CTR_BACK : `PRED_CTR_FWD};
            end
            `PRED_KIND_NONE: begin
                freshHist = '0;             // no branch, nothing to learn
            end
            default: begin
                freshHist = '1;             // unconditional, always taken
            end
        endcase
    end

    ////////////////////////////////////////
    // resolve training rule
    ////////////////////////////////////////
    always_comb begin
        sel = old[9:8];
        cur = old[{sel, 1'b0} +: 2];        // counter for history value sel
        if (taken) begin
            bumped = (cur == 2'b11) ? cur : cur + 2'b01;   // saturate high
        end else begin
            bumped = (cur == 2'b00) ? cur : cur - 2'b01;   // saturate low
        end
        trainHist = old;
        trainHist[{sel, 1'b0} +: 2] = bumped;
        trainHist[9:8] = {old[8], taken};   // shift in the new outcome
    end

    assign next = fresh ? freshHist : trainHist;

endmodule

`default_nettype wire

//--- verilog/slotTable.sv
`timescale 1ns/100ps
`default_nettype none

`include "predictor_config.svh"

module slotTable (
    input  wire                   clk,
    input  wire                   rstn,

    // install port
    input  wire                   wrEn,         // install into this slot
    input  wire predictorPkg::addrT   wrPC,     // slot instruction address
    input  wire predictorPkg::kindT   wrKind,   // decoded kind
    input  wire predictorPkg::addrT   wrTarget, // decoded target, byte address

    // resolve lookup
    input  wire predictorPkg::addrT   rsPC,     // resolving instruction
    output logic                  rsHit,        // valid entry with matching tag
    output predictorPkg::kindT    rsKind,       // stored kind for resolve

    // predict lookup
    input  wire predictorPkg::addrT   pdPC,     // fetch pair address
    output logic                  pdHit,        // valid entry with matching tag
    output predictorPkg::targetT  pdTarget,     // stored target word address
    output predictorPkg::kindT    pdKind        // stored kind for predict
);
    import predictorPkg::*;

    localparam int unsigned Sets  = 1 << `PRED_INDEX_BITS;
    localparam int unsigned IdxLo = 3;                          // pair offset is pc[2:0]
    localparam int unsigned IdxHi = `PRED_INDEX_BITS + IdxLo - 1;
    localparam int unsigned TagLo = IdxHi + 1;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    logic [Sets-1:0] valid;                     // control state, cleared on reset
    tagT             tagMem    [Sets];          // payload arrays
    targetT          targetMem [Sets];
    kindT            kindMem   [Sets];

    ////////////////////////////////////////
    // address split, pc[2] ignored here
    ////////////////////////////////////////
    indexT wrIndex;
    indexT rsIndex;
    indexT pdIndex;
    tagT   wrTag;
    tagT   rsTag;
    tagT   pdTag;

    assign wrIndex = wrPC[IdxHi:IdxLo];
    assign rsIndex = rsPC[IdxHi:IdxLo];
    assign pdIndex = pdPC[IdxHi:IdxLo];
    assign wrTag   = wrPC[`PRED_ADDR_WIDTH-1:TagLo];
    assign rsTag   = rsPC[`PRED_ADDR_WIDTH-1:TagLo];
    assign pdTag   = pdPC[`PRED_ADDR_WIDTH-1:TagLo];

    // valid bits, set on install, never cleared afterwards
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wrEn) begin
            valid[wrIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrIndex]    <= wrTag;
            targetMem[wrIndex] <= wrTarget[`PRED_ADDR_WIDTH-1:2];  // drop byte bits
            kindMem[wrIndex]   <= wrKind;
        end
    end

    ////////////////////////////////////////
    // lookups, old state until the edge
    ////////////////////////////////////////
    assign rsHit    = valid[rsIndex] && (tagMem[rsIndex] == rsTag);
    assign rsKind   = kindMem[rsIndex];
    assign pdHit    = valid[pdIndex] && (tagMem[pdIndex] == pdTag);
    assign pdTarget = targetMem[pdIndex];
    assign pdKind   = kindMem[pdIndex];

endmodule

`default_nettype wire

//--- verilog/historyTable.sv
`timescale 1ns/100ps
`default_nettype none

`include "predictor_config.svh"

module historyTable (
    input  wire                        clk,
    input  wire                        rstn,

    // install port
    input  wire                        wrEn,      // install into this slot
    input  wire predictorPkg::addrT    wrPC,      // slot instruction address
    input  wire predictorPkg::kindT    wrKind,    // decoded kind
    input  wire predictorPkg::addrT    wrTarget,  // decoded target
    input  wire                        wrTaken,   // decoded outcome

    // resolve port
    input  wire                        rsEn,      // resolve aimed at this slot
    input  wire predictorPkg::addrT    rsPC,      // resolving instruction
    input  wire                        rsTaken,   // real outcome
    input  wire                        rsHit,     // from the slot table
    input  wire predictorPkg::kindT    rsKind,    // from the slot table

    // predict lookup
    input  wire predictorPkg::addrT    pdPC,      // fetch pair address
    output predictorPkg::historyT      pdHistory  // entry for the predict stage
);
    import predictorPkg::*;

    localparam int unsigned Sets  = 1 << `PRED_INDEX_BITS;
    localparam int unsigned IdxHi = `PRED_INDEX_BITS + 2;   // index is pc[7:3]

    logic [Sets-1:0] filled;        // entry written since reset
    historyT         histMem [Sets];

    indexT   wrIndex;
    indexT   rsIndex;
    indexT   pdIndex;
    indexT   writeIndex;            // install index wins over resolve
    logic    backward;
    logic    train;                 // resolve hit on a conditional branch
    logic    writeEn;
    historyT rsOld;
    historyT nextHist;

    assign wrIndex = wrPC[IdxHi:3];
    assign rsIndex = rsPC[IdxHi:3];
    assign pdIndex = pdPC[IdxHi:3];

    assign backward   = wrTarget[`PRED_ADDR_WIDTH-1:2] < wrPC[`PRED_ADDR_WIDTH-1:2];
    assign train      = rsEn && rsHit && (rsKind == `PRED_KIND_COND);
    assign writeEn    = wrEn || train;
    assign writeIndex = wrEn ? wrIndex : rsIndex;
    assign rsOld      = filled[rsIndex] ? histMem[rsIndex] : '0;
    assign pdHistory  = filled[pdIndex] ? histMem[pdIndex] : '0;

    historyNext rule (
        .fresh    (wrEn),
        .kind     (wrKind),
        .backward (backward),
        .taken    (wrEn ? wrTaken : rsTaken),
        .old      (rsOld),
        .next     (nextHist)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            filled <= '0;
        end else if (writeEn) begin
            filled[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            histMem[writeIndex] <= nextHist;     // single write port
        end
    end

endmodule

`default_nettype wire

//--- verilog/predictStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "predictor_config.svh"

module predictStage (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        req,        // predict request this cycle
    input  wire                        hit,        // slot table lookup hit
    input  wire predictorPkg::kindT    kind,       // stored kind
    input  wire predictorPkg::targetT  target,     // stored target
    input  wire predictorPkg::historyT history,    // stored history entry
    output logic                       valid,      // prediction ready
    output logic                       hitOut,
    output logic                       takenOut,
    output predictorPkg::targetT       targetOut
);
    import predictorPkg::*;

    logic [1:0] outcome;            // recent outcome bits
    counterT    ctr;                // counter they select
    logic       takenNow;           // combinational taken

    ////////////////////////////////////////
    // taken decision
    ////////////////////////////////////////
    always_comb begin
        outcome = history[9:8];
        ctr     = history[{outcome, 1'b0} +: 2];
        if (!hit) begin
            takenNow = 1'b0;                    // miss never redirects
        end else if (kind[1]) begin
            takenNow = 1'b1;                    // jump or call
        end else if (kind == `PRED_KIND_COND) begin
            takenNow = ctr[1];                  // counter msb
        end else begin
            takenNow = 1'b0;
        end
    end

    // one cycle of latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid    <= 1'b0;
            hitOut   <= 1'b0;
            takenOut <= 1'b0;
        end else begin
            valid <= req;
            if (req) begin
                hitOut   <= hit;
                takenOut <= takenNow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            targetOut <= target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pairPredictor.sv
`timescale 1ns/100ps
`default_nettype none

`include "predictor_config.svh"

module pairPredictor (
    input  wire                        clk,
    input  wire                        rstn,

    // install, decode stage
    input  wire                        idEn,
    input  wire predictorPkg::addrT    idPC,          // pair address
    input  wire                        usefulLower,
    input  wire                        usefulUpper,
    input  wire predictorPkg::kindT    kindLower,
    input  wire predictorPkg::kindT    kindUpper,
    input  wire predictorPkg::addrT    targetLower,
    input  wire predictorPkg::addrT    targetUpper,
    input  wire                        takenLower,
    input  wire                        takenUpper,

    // resolve, execute stage
    input  wire                        exEn,
    input  wire predictorPkg::addrT    exPC,          // bit 2 picks the slot
    input  wire                        exTaken,

    // predict, fetch stage
    input  wire                        ifReq,
    input  wire predictorPkg::addrT    ifPC,
    output logic                       ifValid,
    output logic                       hitLower,
    output logic                       hitUpper,
    output logic                       takenPredLower,
    output logic                       takenPredUpper,
    output predictorPkg::targetT       targetPredLower,
    output predictorPkg::targetT       targetPredUpper
);
    import predictorPkg::*;

    ////////////////////////////////////////
    // per slot enables and addresses
    ////////////////////////////////////////
    logic    idEnLower;
    logic    idEnUpper;
    logic    exEnLower;
    logic    exEnUpper;
    addrT    pcLower;               // lower instruction of the pair
    addrT    pcUpper;               // upper instruction of the pair

    assign idEnLower = idEn & usefulLower;
    assign idEnUpper = idEn & usefulUpper;
    assign exEnLower = exEn & ~exPC[2];
    assign exEnUpper = exEn &  exPC[2];
    assign pcLower   = {idPC[`PRED_ADDR_WIDTH-1:3], 3'b000};
    assign pcUpper   = {idPC[`PRED_ADDR_WIDTH-1:3], 3'b100};

    logic    rsHitLower, rsHitUpper;
    kindT    rsKindLower, rsKindUpper;
    logic    pdHitLower, pdHitUpper;
    targetT  pdTargetLower, pdTargetUpper;
    kindT    pdKindLower, pdKindUpper;
    historyT pdHistLower, pdHistUpper;

    ////////////////////////////////////////
    // lower column
    ////////////////////////////////////////
    slotTable slotLower (
        .clk (clk), .rstn (rstn),
        .wrEn (idEnLower), .wrPC (pcLower), .wrKind (kindLower), .wrTarget (targetLower),
        .rsPC (exPC), .rsHit (rsHitLower), .rsKind (rsKindLower),
        .pdPC (ifPC), .pdHit (pdHitLower), .pdTarget (pdTargetLower), .pdKind (pdKindLower)
    );

    historyTable histLower (
        .clk (clk), .rstn (rstn),
        .wrEn (idEnLower), .wrPC (pcLower), .wrKind (kindLower),
        .wrTarget (targetLower), .wrTaken (takenLower),
        .rsEn (exEnLower), .rsPC (exPC), .rsTaken (exTaken),
        .rsHit (rsHitLower), .rsKind (rsKindLower),
        .pdPC (ifPC), .pdHistory (pdHistLower)
    );

    predictStage predLower (
        .clk (clk), .rstn (rstn), .req (ifReq),
        .hit (pdHitLower), .kind (pdKindLower), .target (pdTargetLower),
        .history (pdHistLower),
        .valid (ifValid), .hitOut (hitLower), .takenOut (takenPredLower),
        .targetOut (targetPredLower)
    );

    ////////////////////////////////////////
    // upper column
    ////////////////////////////////////////
    slotTable slotUpper (
        .clk (clk), .rstn (rstn),
        .wrEn (idEnUpper), .wrPC (pcUpper), .wrKind (kindUpper), .wrTarget (targetUpper),
        .rsPC (exPC), .rsHit (rsHitUpper), .rsKind (rsKindUpper),
        .pdPC (ifPC), .pdHit (pdHitUpper), .pdTarget (pdTargetUpper), .pdKind (pdKindUpper)
    );

    historyTable histUpper (
        .clk (clk), .rstn (rstn),
        .wrEn (idEnUpper), .wrPC (pcUpper), .wrKind (kindUpper),
        .wrTarget (targetUpper), .wrTaken (takenUpper),
        .rsEn (exEnUpper), .rsPC (exPC), .rsTaken (exTaken),
        .rsHit (rsHitUpper), .rsKind (rsKindUpper),
        .pdPC (ifPC), .pdHistory (pdHistUpper)
    );

    predictStage predUpper (
        .clk (clk), .rstn (rstn), .req (ifReq),
        .hit (pdHitUpper), .kind (pdKindUpper), .target (pdTargetUpper),
        .history (pdHistUpper),
        .valid (), .hitOut (hitUpper), .takenOut (takenPredUpper),   // valid same as lower
        .targetOut (targetPredUpper)
    );

endmodule

`default_nettype wire

//--- bench/predictorModel.svh
`ifndef PREDICTOR_MODEL_SVH
`define PREDICTOR_MODEL_SVH

////////////////////////////////////////
// reference state, [0] lower, [1] upper
////////////////////////////////////////
logic        mValid  [2][32];
tagT         mTag    [2][32];
targetT      mTarget [2][32];
kindT        mKind   [2][32];
historyT     mHist   [2][32];
logic [63:0] expQ    [$];                       // {lower, upper} of {hit, taken, target}

function automatic historyT freshEntry(input kindT kind, input logic backward,
                                       input logic taken);
    historyT h;
    if (kind[1]) begin
        h = '1;                                 // jump, everything set
    end else if (kind == `PRED_KIND_COND) begin
        if (backward) begin
            h = {backward, taken, 2'b10, 2'b10, 2'b10, 2'b01};
        end else begin
            h = {backward, taken, 2'b10, 2'b01, 2'b01, 2'b01};
        end
    end else begin
        h = '0;
    end
    return h;
endfunction

// counter named by the two outcome bits
function automatic counterT pickCounter(input historyT h);
    case (h[9:8])
        2'b11:   return h[7:6];
        2'b10:   return h[5:4];
        2'b01:   return h[3:2];
        default: return h[1:0];
    endcase
endfunction

function automatic historyT trainEntry(input historyT old, input logic taken);
    historyT h;
    counterT c;
    c = pickCounter(old);
    if (taken && c != 2'b11) begin
        c = c + 2'b01;                          // count up, stop at 11
    end else if (!taken && c != 2'b00) begin
        c = c - 2'b01;                          // count down, stop at 00
    end
    h = old;
    case (old[9:8])
        2'b11:   h[7:6] = c;
        2'b10:   h[5:4] = c;
        2'b01:   h[3:2] = c;
        default: h[1:0] = c;
    endcase
    h[9:8] = {old[8], taken};                   // shift the outcome in
    return h;
endfunction

function automatic logic [31:0] predictSlot(input int slot, input addrT pc);
    indexT   idx;
    logic    hit;
    logic    taken;
    counterT ctr;
    idx   = pc[7:3];
    hit   = mValid[slot][idx] && (mTag[slot][idx] == pc[31:8]);
    ctr   = pickCounter(mHist[slot][idx]);
    taken = 1'b0;
    if (hit && mKind[slot][idx][1]) begin
        taken = 1'b1;
    end else if (hit && mKind[slot][idx] == `PRED_KIND_COND) begin
        taken = ctr[1];
    end
    return {hit, taken, mTarget[slot][idx]};
endfunction

task automatic installEntry(input int slot, input kindT kind, input addrT target,
                            input logic taken);
    addrT  pc;
    indexT idx;
    pc  = {idPC[31:3], slot[0], 2'b00};         // slot instruction address
    idx = pc[7:3];
    mValid[slot][idx]  = 1'b1;
    mTag[slot][idx]    = pc[31:8];
    mTarget[slot][idx] = target[31:2];
    mKind[slot][idx]   = kind;
    mHist[slot][idx]   = freshEntry(kind, target[31:2] < pc[31:2], taken);
endtask

task automatic trainOnResolve(input logic blocked);
    int    slot;
    indexT idx;
    slot = exPC[2] ? 1 : 0;
    idx  = exPC[7:3];
    if (!blocked && mValid[slot][idx] && mTag[slot][idx] == exPC[31:8]
            && mKind[slot][idx] == `PRED_KIND_COND) begin
        mHist[slot][idx] = trainEntry(mHist[slot][idx], exTaken);
    end
endtask

// one rising edge, predict sees the state before the writes
task automatic stepReference();
    logic blocked;
    if (ifReq) begin
        expQ.push_back({predictSlot(0, ifPC), predictSlot(1, ifPC)});
    end
    blocked = idEn && (exPC[2] ? usefulUpper : usefulLower);     // install wins
    if (exEn) begin
        trainOnResolve(blocked);
    end
    if (idEn && usefulLower) begin
        installEntry(0, kindLower, targetLower, takenLower);
    end
    if (idEn && usefulUpper) begin
        installEntry(1, kindUpper, targetUpper, takenUpper);
    end
endtask

task automatic clearReference();
    for (int s = 0; s < 2; s++) begin
        for (int i = 0; i < 32; i++) begin
            mValid[s][i] = 1'b0;
        end
    end
    expQ.delete();
endtask

`endif

//--- bench/pairPredictorTb.sv
`timescale 1ns/100ps
`include "predictor_config.svh"
`default_nettype none

module pairPredictorTb;
    import predictorPkg::*;

    localparam int unsigned WaitLimit = 8;          // cycles for one prediction
    localparam int unsigned RunLimit  = 10000;      // whole run
    localparam addrT        PcA = 32'h0040_1a48;    // set 9
    localparam addrT        PcB = 32'h0040_1b48;    // set 9 with another tag

    logic   clk;
    logic   rstn;
    logic   idEn;
    logic   usefulLower;
    logic   usefulUpper;
    logic   takenLower;
    logic   takenUpper;
    addrT   idPC;
    addrT   targetLower;
    addrT   targetUpper;
    addrT   exPC;
    addrT   ifPC;
    kindT   kindLower;
    kindT   kindUpper;
    logic   exEn;
    logic   exTaken;
    logic   ifReq;
    logic   ifValid;
    logic   hitLower;
    logic   hitUpper;
    logic   takenPredLower;
    logic   takenPredUpper;
    targetT targetPredLower;
    targetT targetPredUpper;
    string  testName;
    integer seed;

    `include "predictorModel.svh"

    pairPredictor dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    initial begin
        for (int n = 0; n < RunLimit; n++) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", RunLimit);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////
    task automatic reportMismatch(input string field, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("FAILED %s %s: expected %h, actual %h", testName, field, exp, act);
        $display("SOME TESTS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic stopWithError(input string what);
        $display("%s: %s", testName, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compareField(input string field, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else reportMismatch(field, exp, act);
    endtask

    // one sampling edge then check what came back
    task automatic advanceAndCheck();
        logic [63:0] exp;
        int          waited;
        stepReference();
        if (!ifReq) begin
            @(negedge clk);
            assert (ifValid === 1'b0) else stopWithError("ifValid set without a request");
        end else begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (ifValid !== 1'b1 && waited < WaitLimit);
            if (ifValid !== 1'b1) begin
                stopWithError("no prediction came back before the timeout");
            end
            assert (waited == 1) else reportMismatch("latency", 32'd1, 32'(waited));
            exp = expQ.pop_front();
            compareField("hitLower", 32'(exp[63]), 32'(hitLower));
            compareField("takenPredLower", 32'(exp[62]), 32'(takenPredLower));
            if (exp[63]) begin                      // target only meaningful on a hit
                compareField("targetPredLower", 32'(exp[61:32]), 32'(targetPredLower));
            end
            compareField("hitUpper", 32'(exp[31]), 32'(hitUpper));
            compareField("takenPredUpper", 32'(exp[30]), 32'(takenPredUpper));
            if (exp[31]) begin
                compareField("targetPredUpper", 32'(exp[29:0]), 32'(targetPredUpper));
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic idleInputs();
        idEn        = 1'b0;
        idPC        = '0;
        usefulLower = 1'b0;
        usefulUpper = 1'b0;
        kindLower   = `PRED_KIND_NONE;
        kindUpper   = `PRED_KIND_NONE;
        targetLower = '0;
        targetUpper = '0;
        takenLower  = 1'b0;
        takenUpper  = 1'b0;
        exEn        = 1'b0;
        exPC        = '0;
        exTaken     = 1'b0;
        ifReq       = 1'b0;
        ifPC        = '0;
    endtask

    task automatic driveInstall(input addrT pc, input logic [1:0] useful, input kindT kl,
                                input kindT ku, input addrT tl, input addrT tu,
                                input logic [1:0] taken);
        idEn        = 1'b1;
        idPC        = pc;
        usefulLower = useful[0];
        usefulUpper = useful[1];
        kindLower   = kl;
        kindUpper   = ku;
        targetLower = tl;
        targetUpper = tu;
        takenLower  = taken[0];
        takenUpper  = taken[1];
    endtask

    task automatic requestPredict(input addrT pc);
        ifReq = 1'b1;
        ifPC  = pc;
        advanceAndCheck();
        ifReq = 1'b0;
    endtask

    // four tags per set so lookups hit often
    function automatic addrT poolAddress(input logic [1:0] tag, input indexT idx);
        return {22'h2a5f31, tag, idx, 3'b000};
    endfunction

    task automatic driveRandomMix();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        idEn        = (a[1:0] == 2'b00);
        usefulLower = a[2];
        usefulUpper = a[3];
        kindLower   = a[5:4];
        kindUpper   = a[7:6];
        takenLower  = a[8];
        takenUpper  = a[9];
        idPC        = poolAddress(a[11:10], a[16:12]);
        targetLower = idPC + {{20{b[11]}}, b[11:0]};    // near target in either direction
        targetUpper = idPC + {{20{b[23]}}, b[23:12]};
        exEn        = b[24] | b[25];
        exPC        = poolAddress(c[1:0], c[6:2]) | {29'd0, c[7], 2'b00};
        exTaken     = c[8];
        ifReq       = c[9] | c[10];
        ifPC        = poolAddress(c[12:11], c[17:13]) | {29'd0, c[20:18]};
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        seed     = 32'ha377_7f94;
        testName = "reset";
        rstn     = 1'b0;
        idleInputs();
        clearReference();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        compareField("ifValid", 32'd0, 32'(ifValid));
        compareField("hitLower", 32'd0, 32'(hitLower));
        compareField("hitUpper", 32'd0, 32'(hitUpper));
        compareField("takenPredLower", 32'd0, 32'(takenPredLower));
        compareField("takenPredUpper", 32'd0, 32'(takenPredUpper));
        requestPredict(32'h0bad_c0d8);              // empty table so both slots miss

        // jump in the lower slot and backward branch in the upper
        testName = "install";
        driveInstall(PcA, 2'b11, 2'b10, `PRED_KIND_COND, 32'h0040_2000, 32'h0040_1000, 2'b10);
        advanceAndCheck();
        idleInputs();
        requestPredict(PcA);

        testName = "resolve";
        for (int i = 0; i < 12; i++) begin
            exEn    = 1'b1;
            exPC    = PcA | 32'h4;
            exTaken = 1'($random(seed));
            ifReq   = 1'b1;                         // predict in the same cycle sees old state
            ifPC    = PcA;
            advanceAndCheck();
        end
        exPC = PcA;                                 // jump slot is never trained
        advanceAndCheck();
        exPC = PcA + 32'h0000_0204;                 // tag miss
        advanceAndCheck();
        idleInputs();
        requestPredict(PcA);

        testName = "alias";
        requestPredict(PcB);
        driveInstall(PcB, 2'b01, `PRED_KIND_COND, `PRED_KIND_NONE, 32'h0040_1c00, '0, 2'b01);
        advanceAndCheck();
        idleInputs();
        requestPredict(PcA);                        // lower replaced
        requestPredict(PcB);

        testName = "same cycle";
        driveInstall(PcA, 2'b10, `PRED_KIND_NONE, `PRED_KIND_COND, '0, 32'h0040_1b00, 2'b00);
        exEn    = 1'b1;
        exPC    = PcA | 32'h4;
        exTaken = 1'b1;
        ifReq   = 1'b1;
        ifPC    = PcA;
        advanceAndCheck();
        idleInputs();
        requestPredict(PcA);

        testName = "random";
        for (int i = 0; i < 3000; i++) begin
            driveRandomMix();
            advanceAndCheck();
        end
        idleInputs();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
+incdir+bench
verilog/predictorPkg.sv
verilog/historyNext.sv
verilog/slotTable.sv
verilog/historyTable.sv
verilog/predictStage.sv
verilog/pairPredictor.sv
bench/pairPredictorTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := pairPredictorTb
RTL_TOP    := pairPredictor
FILELIST   := src.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the binary exits non-zero on $fatal
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
